// ==== hdl/ps2_config.svh ====
`ifndef PS2_CONFIG_SVH
`define PS2_CONFIG_SVH

// Scan-code FIFO entries
`define PS2_FIFO_DEPTH 8

// System clocks without activity before the line counts as quiet
`define PS2_IDLE_CYCLES 10000

// AXI4-Lite register byte addresses
`define PS2_ADDR_STATUS 4'h0
`define PS2_ADDR_KEY    4'h4
`define PS2_ADDR_COUNT  4'h8
`define PS2_ADDR_CTRL   4'hC

`endif

// ==== hdl/ps2_pkg.sv ====
package ps2_pkg;

    typedef logic [7:0]  scan_code_t;
    typedef logic [7:0]  ascii_t;
    typedef logic [15:0] key_count_t;   // Release counter
    typedef logic [3:0]  axil_addr_t;   // Register byte address
    typedef logic [31:0] axil_data_t;

    // One accepted PS/2 frame
    typedef struct packed {
        scan_code_t code;
    } ps2_frame_t;

    // Decoded key, 18 bits
    typedef struct packed {
        scan_code_t code;
        ascii_t     ascii;
        logic       released;   // Came after F0
        logic       extended;   // Came after E0
    } key_event_t;

    // Prefix tracking in the decoder
    typedef enum logic [1:0] {
        IDLE,
        GOT_E0,
        GOT_F0,
        GOT_E0F0
    } dec_state_t;

endpackage

// ==== hdl/ps2_frame_rx.sv ====
`timescale 1ns/1ns
`include "ps2_config.svh"

module ps2_frame_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       frame_valid,
    output ps2_frame_t frame,
    output logic       frame_error
);

    localparam int TIMER_W = $clog2(`PS2_IDLE_CYCLES + 1);

    logic [1:0]         clk_sync;    // Two-flop synchronizer
    logic [1:0]         data_sync;
    logic               clk_prev;    // Edge-detect register
    logic               clk_fall;
    logic [9:0]         shift;       // Start, data, parity, LSB first
    logic [3:0]         bit_cnt;
    logic [TIMER_W-1:0] gap_timer;   // Cycles since last PS/2 edge
    logic               bits_ok;

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_sync  <= 2'b11;      // Lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // Start low, odd parity over data and parity, stop high on the line now
    assign bits_ok = ~shift[0] & (^shift[9:1]) & data_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_cnt     <= '0;
            gap_timer   <= '0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
            if (clk_fall) begin
                gap_timer <= '0;
                if (bit_cnt == 4'd10) begin      // Stop bit edge
                    bit_cnt     <= '0;
                    frame_valid <= bits_ok;
                    frame_error <= ~bits_ok;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != '0) begin
                // A frame stalled too long is dropped so the next one aligns
                if (gap_timer == TIMER_W'(`PS2_IDLE_CYCLES)) begin
                    bit_cnt   <= '0;
                    gap_timer <= '0;
                end else begin
                    gap_timer <= gap_timer + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_fall && bit_cnt != 4'd10) begin
            shift <= {data_sync[1], shift[9:1]};
        end
        if (clk_fall && bit_cnt == 4'd10) begin
            frame.code <= shift[8:1];        // Data bits only
        end
    end

endmodule

// ==== hdl/scan_fifo.sv ====
`timescale 1ns/1ns
`include "ps2_config.svh"

module scan_fifo
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push,
    input  scan_code_t push_code,
    output logic       code_valid,
    output scan_code_t code,
    input  logic       code_pop,
    input  logic       clear_overflow,
    output logic       overflow
);

    localparam int DEPTH = `PS2_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    scan_code_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // Occupancy, all entries usable
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full       = (count == CNT_W'(DEPTH));
    assign code_valid = (count != '0);
    assign code       = mem[rd_ptr];   // Oldest entry
    assign do_pop     = code_pop & code_valid;
    assign do_push    = push & (~full | do_pop);  // Room freed by a same-cycle pop

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && !do_push) begin
                overflow <= 1'b1;          // Code lost, set wins over clear
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

endmodule

// ==== hdl/key_decoder.sv ====
`timescale 1ns/1ns
`include "ps2_config.svh"

module key_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       code_valid,
    input  scan_code_t code,
    output logic       code_pop,
    input  logic       frame_seen,
    output logic       event_valid,
    output key_event_t key_event,
    input  logic       event_ack,
    input  logic       clear_count,
    output key_count_t release_count,
    output logic       idle
);

    localparam int         IDLE_W       = $clog2(`PS2_IDLE_CYCLES + 2);
    localparam scan_code_t EXT_PREFIX   = 8'hE0;
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

    dec_state_t        state;
    logic              is_prefix;
    logic              is_break;
    logic              is_ext;
    logic [IDLE_W-1:0] idle_timer;

    // Letters and digits only
    function automatic ascii_t scan_to_ascii(input scan_code_t sc);
        ascii_t ch;
        case (sc)
            8'h1C: ch = "A";
            8'h32: ch = "B";
            8'h21: ch = "C";
            8'h23: ch = "D";
            8'h24: ch = "E";
            8'h2B: ch = "F";
            8'h34: ch = "G";
            8'h33: ch = "H";
            8'h43: ch = "I";
            8'h3B: ch = "J";
            8'h42: ch = "K";
            8'h4B: ch = "L";
            8'h3A: ch = "M";
            8'h31: ch = "N";
            8'h44: ch = "O";
            8'h4D: ch = "P";
            8'h15: ch = "Q";
            8'h2D: ch = "R";
            8'h1B: ch = "S";
            8'h2C: ch = "T";
            8'h3C: ch = "U";
            8'h2A: ch = "V";
            8'h1D: ch = "W";
            8'h22: ch = "X";
            8'h35: ch = "Y";
            8'h1A: ch = "Z";
            8'h45: ch = "0";
            8'h16: ch = "1";
            8'h1E: ch = "2";
            8'h26: ch = "3";
            8'h25: ch = "4";
            8'h2E: ch = "5";
            8'h36: ch = "6";
            8'h3D: ch = "7";
            8'h3E: ch = "8";
            8'h46: ch = "9";
            default: ch = 8'h00;
        endcase
        return ch;
    endfunction

    assign code_pop  = code_valid & ~event_valid;   // Held event stalls the FIFO
    assign is_prefix = (code == EXT_PREFIX) || (code == BREAK_PREFIX);
    assign is_break  = (state == GOT_F0) || (state == GOT_E0F0);
    assign is_ext    = (state == GOT_E0) || (state == GOT_E0F0);
    assign idle      = idle_timer > IDLE_W'(`PS2_IDLE_CYCLES);

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            event_valid   <= 1'b0;
            release_count <= '0;
        end else begin
            if (event_ack) begin
                event_valid <= 1'b0;
            end
            if (clear_count) begin
                release_count <= '0;
            end else if (code_pop && !is_prefix && is_break && release_count != '1) begin
                release_count <= release_count + 1'b1;   // Saturates
            end
            if (code_pop) begin
                case (code)
                    EXT_PREFIX:   state <= is_break ? GOT_E0F0 : GOT_E0;
                    BREAK_PREFIX: state <= is_ext ? GOT_E0F0 : GOT_F0;
                    default: begin
                        state       <= IDLE;     // Key code ends the sequence
                        event_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (code_pop && !is_prefix) begin
            key_event.code     <= code;
            key_event.ascii    <= is_ext ? 8'h00 : scan_to_ascii(code);
            key_event.released <= is_break;
            key_event.extended <= is_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_timer <= '0;
        end else if (frame_seen) begin
            idle_timer <= '0;
        end else if (!idle) begin
            idle_timer <= idle_timer + 1'b1;   // Stops once idle
        end
    end

endmodule

// ==== hdl/ps2_axil_regs.sv ====
`timescale 1ns/1ns
`include "ps2_config.svh"

module ps2_axil_regs
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output axil_data_t rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    input  logic       event_valid,
    input  key_event_t key_event,
    output logic       event_ack,
    input  logic       overflow,
    input  logic       frame_error,
    input  logic       idle,
    input  key_count_t release_count,
    output logic       clear_overflow,
    output logic       clear_count
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic       ar_fire;
    logic       rd_hit;
    logic       key_pop;
    axil_data_t rd_word;
    logic       aw_held;      // Address arrived before data
    logic       w_held;       // Data arrived before address
    axil_addr_t aw_addr_q;
    axil_data_t w_data_q;
    logic       aw_fire;
    logic       w_fire;
    logic       do_write;
    axil_addr_t wr_addr;
    axil_data_t wr_data;
    logic       wr_hit;
    logic       ctrl_write;
    logic       frame_err_flag;   // Sticky

    assign arready = ~rvalid;
    assign ar_fire = arvalid & arready;

    always_comb begin
        rd_hit  = 1'b1;
        rd_word = '0;
        case (araddr)
            `PS2_ADDR_STATUS: rd_word = {28'd0, idle, frame_err_flag, overflow, event_valid};
            `PS2_ADDR_KEY: begin
                if (event_valid) begin
                    rd_word = {1'b1, 13'd0, key_event.extended, key_event.released,
                               key_event.ascii, key_event.code};
                end
            end
            `PS2_ADDR_COUNT:  rd_word = {16'd0, release_count};
            `PS2_ADDR_CTRL:   rd_word = '0;   // Write only
            default:          rd_hit  = 1'b0;
        endcase
    end

    assign key_pop = ar_fire & event_valid & (araddr == `PS2_ADDR_KEY);

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid    <= 1'b0;
            event_ack <= 1'b0;
        end else begin
            event_ack <= key_pop;     // Event already captured in rdata
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_word;
            rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

    assign awready    = ~bvalid & ~aw_held;
    assign wready     = ~bvalid & ~w_held;
    assign aw_fire    = awvalid & awready;
    assign w_fire     = wvalid & wready;
    assign wr_addr    = aw_held ? aw_addr_q : awaddr;
    assign wr_data    = w_held ? w_data_q : wdata;
    assign do_write   = (aw_held | aw_fire) & (w_held | w_fire);
    assign wr_hit     = wr_addr inside {`PS2_ADDR_STATUS, `PS2_ADDR_KEY,
                                        `PS2_ADDR_COUNT, `PS2_ADDR_CTRL};
    assign ctrl_write = do_write & (wr_addr == `PS2_ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid         <= 1'b0;
            aw_held        <= 1'b0;
            w_held         <= 1'b0;
            clear_overflow <= 1'b0;
            clear_count    <= 1'b0;
            frame_err_flag <= 1'b0;
        end else begin
            clear_overflow <= ctrl_write & wr_data[0];
            clear_count    <= ctrl_write & wr_data[2];
            if (frame_error) begin
                frame_err_flag <= 1'b1;
            end else if (ctrl_write && wr_data[1]) begin
                frame_err_flag <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (do_write) begin
                bvalid  <= 1'b1;
                aw_held <= 1'b0;
                w_held  <= 1'b0;
            end else begin
                if (aw_fire) begin
                    aw_held <= 1'b1;
                end
                if (w_fire) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            aw_addr_q <= awaddr;
        end
        if (w_fire) begin
            w_data_q <= wdata;
        end
        if (do_write) begin
            bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

// ==== hdl/ps2_keyboard_top.sv ====
`timescale 1ns/1ns

module ps2_keyboard_top
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  axil_addr_t awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  axil_data_t wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  axil_addr_t araddr,
    input  logic       arvalid,
    output logic       arready,
    output axil_data_t rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    logic       frame_valid;
    ps2_frame_t frame;
    logic       frame_error;
    logic       code_valid;
    scan_code_t code;
    logic       code_pop;
    logic       overflow;
    logic       clear_overflow;
    logic       event_valid;
    key_event_t key_event;
    logic       event_ack;
    key_count_t release_count;
    logic       clear_count;
    logic       idle;

    ps2_frame_rx ps2_frame_rx_i (
        .clk         (clk),
        .reset       (reset),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_error (frame_error)
    );

    scan_fifo scan_fifo_i (
        .clk            (clk),
        .reset          (reset),
        .push           (frame_valid),
        .push_code      (frame.code),
        .code_valid     (code_valid),
        .code           (code),
        .code_pop       (code_pop),
        .clear_overflow (clear_overflow),
        .overflow       (overflow)
    );

    key_decoder key_decoder_i (
        .clk           (clk),
        .reset         (reset),
        .code_valid    (code_valid),
        .code          (code),
        .code_pop      (code_pop),
        .frame_seen    (frame_valid),     // Any good frame restarts the idle timer
        .event_valid   (event_valid),
        .key_event     (key_event),
        .event_ack     (event_ack),
        .clear_count   (clear_count),
        .release_count (release_count),
        .idle          (idle)
    );

    ps2_axil_regs ps2_axil_regs_i (
        .clk            (clk),
        .reset          (reset),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready),
        .event_valid    (event_valid),
        .key_event      (key_event),
        .event_ack      (event_ack),
        .overflow       (overflow),
        .frame_error    (frame_error),
        .idle           (idle),
        .release_count  (release_count),
        .clear_overflow (clear_overflow),
        .clear_count    (clear_count)
    );

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100    // ns
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== sim/ps2_tb.sv ====
`timescale 1ns/1ns
`include "ps2_config.svh"

module ps2_tb
    import ps2_pkg::*;
();

    localparam int BUS_TIMEOUT = 100;    // Cycles per bus handshake
    localparam int EVENT_POLLS = 50;     // STATUS reads before giving up on an event
    localparam int IDLE_POLLS  = 6000;
    localparam int PS2_HALF    = 10;     // System clocks per PS/2 half period
    localparam int NUM_KEYS    = 8;

    // Set 2 make codes with A first
    localparam logic [26*8-1:0] LETTER_CODES = {
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    localparam logic [10*8-1:0] DIGIT_CODES = {
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
    localparam logic [5*8-1:0] EXT_CODES = {8'h75, 8'h72, 8'h6B, 8'h74, 8'h71};  // Arrows, delete

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    axil_data_t wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    int          cycle_cnt = 0;
    int          last_frame_cycle = 0;   // Stop edge of the last good frame
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;
    int unsigned seed_ret;
    logic        ref_ext;
    logic        ref_brk;
    key_count_t  ref_count;
    axil_data_t  exp_key_q[$];           // KEY words still to be read
    string       chk_name_q[$];
    axil_data_t  chk_exp_q[$];
    axil_data_t  chk_act_q[$];

    tb_clock clock_gen_i (.clk(clk));

    ps2_keyboard_top ps2_keyboard_top_i (
        .clk(clk), .reset(reset), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Drains the queued checks
    always @(posedge clk) begin : compare_proc
        string      name;
        axil_data_t exp_v;
        axil_data_t act_v;
        while (chk_name_q.size() != 0) begin
            name  = chk_name_q.pop_front();
            exp_v = chk_exp_q.pop_front();
            act_v = chk_act_q.pop_front();
            checks++;
            assert (act_v === exp_v) else begin
                mismatches++;
                $display("MISMATCH %s: expected %h, actual %h", name, exp_v, act_v);
            end
        end
    end

    function automatic ascii_t ascii_of(input scan_code_t sc);
        ascii_t ch;
        int     i;
        ch = 8'h00;
        for (i = 0; i < 26; i++) begin
            if (LETTER_CODES[(25 - i)*8 +: 8] == sc) ch = ascii_t'(8'h41 + i);
        end
        for (i = 0; i < 10; i++) begin
            if (DIGIT_CODES[(9 - i)*8 +: 8] == sc) ch = ascii_t'(8'h30 + i);
        end
        return ch;
    endfunction

    // Expected KEY word is zero while a prefix is pending
    function automatic axil_data_t ref_decode(input scan_code_t sc);
        axil_data_t word;
        word = '0;
        if (sc == 8'hE0) begin
            ref_ext = 1'b1;
        end else if (sc == 8'hF0) begin
            ref_brk = 1'b1;
        end else begin
            word = {1'b1, 13'd0, ref_ext, ref_brk, (ref_ext ? 8'h00 : ascii_of(sc)), sc};
            if (ref_brk && ref_count != 16'hFFFF) ref_count++;
            ref_ext = 1'b0;
            ref_brk = 1'b0;
        end
        return word;
    endfunction

    function automatic scan_code_t pick_key();
        int idx;
        idx = $urandom % 36;
        if (idx < 26) return LETTER_CODES[(25 - idx)*8 +: 8];
        return DIGIT_CODES[(35 - idx)*8 +: 8];
    endfunction

    task automatic expect_word(input string name, input axil_data_t exp, input axil_data_t act);
        chk_name_q.push_back(name);
        chk_exp_q.push_back(exp);
        chk_act_q.push_back(act);
    endtask

    // Device model sends start, 8 data bits LSB first, parity and stop
    task automatic send_frame(input scan_code_t sc, input logic bad_parity, input logic bad_stop);
        logic [10:0] bits;
        int          i;
        bits = {~bad_stop, ~(^sc) ^ bad_parity, sc, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(negedge clk);
            ps2_data = bits[i];
            repeat (PS2_HALF / 2) @(negedge clk);
            ps2_clk = 1'b0;
            if (i == 10 && !bad_parity && !bad_stop) begin
                last_frame_cycle = cycle_cnt;
            end
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
            repeat (PS2_HALF / 2 - 1) @(negedge clk);
        end
        ps2_data = 1'b1;
        repeat (2 * PS2_HALF) @(negedge clk);   // Gap between frames
    endtask

    task automatic send_code(input scan_code_t sc);
        axil_data_t word;
        send_frame(sc, 1'b0, 1'b0);
        word = ref_decode(sc);
        if (word[31]) exp_key_q.push_back(word);
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                             output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (arready) else begin
            failures++;
            $display("ERROR: read at address %h timed out waiting for arready", addr);
        end
        @(negedge clk);              // Address taken on the edge in between
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        while (!rvalid && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (rvalid) else begin
            failures++;
            $display("ERROR: read at address %h got no read response", addr);
        end
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        n = 0;
        while (!(awready && wready) && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (awready && wready) else begin
            failures++;
            $display("ERROR: write at address %h timed out waiting for awready and wready", addr);
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        while (!bvalid && n < BUS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (bvalid) else begin
            failures++;
            $display("ERROR: write at address %h got no write response", addr);
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic write_ctrl(input axil_data_t data, input string name);
        logic [1:0] resp;
        axil_write(`PS2_ADDR_CTRL, data, resp);
        expect_word(name, 32'h0, {30'd0, resp});   // OKAY
    endtask

    task automatic wait_status(input int bit_idx, input logic value, input int max_polls,
                               input string what);
        axil_data_t st;
        logic [1:0] resp;
        int         polls;
        polls = 0;
        axil_read(`PS2_ADDR_STATUS, st, resp);
        while (st[bit_idx] !== value && polls < max_polls) begin
            axil_read(`PS2_ADDR_STATUS, st, resp);
            polls++;
        end
        assert (st[bit_idx] === value) else begin
            failures++;
            $display("ERROR: %s, STATUS bit %0d never became %0b", what, bit_idx, value);
        end
    endtask

    task automatic read_key(input string name);
        axil_data_t word;
        logic [1:0] resp;
        wait_status(0, 1'b1, EVENT_POLLS, name);
        axil_read(`PS2_ADDR_KEY, word, resp);
        expect_word({name, " rresp"}, 32'h0, {30'd0, resp});   // OKAY
        assert (exp_key_q.size() != 0) else begin
            failures++;
            $display("ERROR: %s read key word %h although no event was expected", name, word);
        end
        if (exp_key_q.size() != 0) expect_word(name, exp_key_q.pop_front(), word);
    endtask

    initial begin : main_seq
        axil_data_t word;
        logic [1:0] resp;
        scan_code_t sc;
        int         i;
        reset    = 1'b1;
        ps2_clk  = 1'b1;             // Lines idle high
        ps2_data = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        ref_ext   = 1'b0;
        ref_brk   = 1'b0;
        ref_count = '0;
        seed_ret = $urandom(32'he713);
        repeat (5) @(negedge clk);
        reset = 1'b0;

        for (i = 0; i < NUM_KEYS; i++) begin
            sc = pick_key();
            send_code(sc);
            read_key("press_release make");
            send_code(8'hF0);
            send_code(sc);
            read_key("press_release break");
        end
        for (i = 0; i < 3; i++) begin
            if (i == 0) begin
                sc = 8'h34;          // Play/pause shares its code with G
            end else begin
                sc = EXT_CODES[($urandom % 5)*8 +: 8];
            end
            send_code(8'hE0);
            send_code(sc);
            read_key("extended make");
            send_code(8'hE0);
            send_code(8'hF0);
            send_code(sc);
            read_key("extended break");
        end

        axil_read(`PS2_ADDR_COUNT, word, resp);
        expect_word("release_count", {16'd0, ref_count}, word);
        write_ctrl(32'h4, "release_count clear bresp");
        ref_count = '0;
        axil_read(`PS2_ADDR_COUNT, word, resp);
        expect_word("release_count cleared", 32'h0, word);

        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("bad_frames flag before", 32'h0, word[2]);
        sc = pick_key();
        send_frame(sc, 1'b1, 1'b0);  // Flipped parity
        send_frame(sc, 1'b0, 1'b1);  // Stop bit low
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("bad_frames flag set", 32'h1, word[2]);
        expect_word("bad_frames no event", 32'h0, word[0]);
        write_ctrl(32'h2, "bad_frames clear bresp");
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("bad_frames flag cleared", 32'h0, word[2]);
        send_code(sc);
        read_key("bad_frames recovery make");
        send_code(8'hF0);
        send_code(sc);
        read_key("bad_frames recovery break");

        // One event held by the decoder plus a full FIFO
        for (i = 0; i < 10; i++) begin
            sc = pick_key();
            if (i < `PS2_FIFO_DEPTH + 1) send_code(sc);
            else send_frame(sc, 1'b0, 1'b0);
        end
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("overflow flag set", 32'h1, word[1]);
        for (i = 0; i < `PS2_FIFO_DEPTH + 1; i++) begin
            read_key("overflow drain");
        end
        axil_read(`PS2_ADDR_KEY, word, resp);
        expect_word("overflow lost code", 32'h0, word);
        write_ctrl(32'h1, "overflow clear bresp");
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("overflow flag cleared", 32'h0, word[1]);

        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("idle low after traffic", 32'h0, word[3]);
        axil_read(`PS2_ADDR_KEY, word, resp);
        expect_word("idle empty key", 32'h0, word);
        wait_status(3, 1'b1, IDLE_POLLS, "idle set");
        expect_word("idle delay", 32'h1, (cycle_cnt - last_frame_cycle) > `PS2_IDLE_CYCLES);
        send_code(pick_key());
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("idle cleared by frame", 32'h0, word[3]);
        read_key("idle wake key");

        send_frame(pick_key(), 1'b1, 1'b0);   // Leaves the frame error flag set
        axil_read(4'h6, word, resp);
        expect_word("bus_error read resp", 32'h2, {30'd0, resp});
        axil_write(4'h6, 32'h7, resp);
        expect_word("bus_error write resp", 32'h2, {30'd0, resp});
        axil_read(`PS2_ADDR_COUNT, word, resp);
        expect_word("bus_error count kept", {16'd0, ref_count}, word);
        axil_read(`PS2_ADDR_STATUS, word, resp);
        expect_word("bus_error flag kept", 32'h1, word[2]);

        assert (exp_key_q.size() == 0) else begin
            failures++;
            $display("ERROR: %0d expected key events were never read", exp_key_q.size());
        end
        repeat (2) @(negedge clk);   // Compare process catches up
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/ps2_pkg.sv
hdl/ps2_frame_rx.sv
hdl/scan_fifo.sv
hdl/key_decoder.sv
hdl/ps2_axil_regs.sv
hdl/ps2_keyboard_top.sv
sim/tb_clock.sv
sim/ps2_tb.sv
